// ==== source/nf_pkg.sv ====
// ================================================
// peripheral subsystem shared definitions
// ================================================

package nf_pkg;

    // bus widths
    localparam int NF_ADDR_W  = 32;                 // bus address width
    localparam int NF_DATA_W  = 32;                 // bus data width

    // address map
    localparam int NF_DEV_LSB = 12;                 // device select starts here
    localparam int NF_DEV_W   = 2;                  // addr[13:12] picks the device
    localparam int NF_OFS_LSB = 2;                  // word aligned byte addresses
    localparam int NF_OFS_W   = NF_DEV_LSB - NF_OFS_LSB; // word offset bits, 10

    // access target
    typedef enum logic [NF_DEV_W-1:0] {
        DEV_RAM  = 2'd0,                            // word RAM
        DEV_GPIO = 2'd1,                            // GPIO block
        DEV_PWM  = 2'd2,                            // PWM block
        DEV_NONE = 2'd3                             // unmapped, answers with error
    } nf_dev_e;

    // GPIO word offsets
    typedef enum logic [1:0] {
        GPIO_GPI = 2'd0,                            // synchronized input, read only
        GPIO_GPO = 2'd1,                            // output value
        GPIO_GPD = 2'd2                             // pin direction
    } nf_gpio_reg_e;

    // PWM word offsets
    typedef enum logic [1:0] {
        PWM_CTRL     = 2'd0,                        // bit 0 enable
        PWM_PRESCALE = 2'd1,                        // clocks per tick minus one
        PWM_PERIOD   = 2'd2,                        // last counter value
        PWM_DUTY     = 2'd3                         // high while counter below this
    } nf_pwm_reg_e;

    // router FSM
    typedef enum logic {
        RTR_IDLE = 1'b0,                            // ready for a request
        RTR_RESP = 1'b1                             // response pending
    } nf_rtr_state_e;

endpackage : nf_pkg

// ==== source/nf_ram.sv ====
// ================================================
// word RAM slave
// ================================================

`timescale 1ns/1ps

module nf_ram #(
    parameter int ram_depth = 64                            // depth in words
) (
    input  logic                             clk,           // clock
    input  logic                             sel,           // acceptance strobe
    input  logic                             we,            // write enable
    input  logic [$clog2(ram_depth)-1:0]     ofs,           // word index
    input  logic [nf_pkg::NF_DATA_W-1:0]     wd,            // write data
    output logic [nf_pkg::NF_DATA_W-1:0]     rd             // registered read data
);

    import nf_pkg::*;

    logic [NF_DATA_W-1:0] mem [ram_depth];                  // storage, no reset

    // one port, write or read per selected edge
    always_ff @(posedge clk) begin
        if (sel) begin
            if (we) begin
                mem[ofs] <= wd;                             // write on acceptance
            end else begin
                rd <= mem[ofs];                             // valid next cycle
            end
        end
    end

endmodule : nf_ram

// ==== source/nf_gpio.sv ====
// ================================================
// GPIO slave
// ================================================

`timescale 1ns/1ps

module nf_gpio #(
    parameter int gpio_w = 8                                // pin count
) (
    input  logic                             clk,           // clock
    input  logic                             rst_n,         // async reset, active low
    input  logic                             sel,           // acceptance strobe
    input  logic                             we,            // write enable
    input  logic [1:0]                       ofs,           // register offset
    input  logic [nf_pkg::NF_DATA_W-1:0]     wd,            // write data
    output logic [nf_pkg::NF_DATA_W-1:0]     rd,            // read data
    input  logic [gpio_w-1:0]                gpi,           // pins in, asynchronous
    output logic [gpio_w-1:0]                gpo,           // pins out
    output logic [gpio_w-1:0]                gpd            // direction
);

    import nf_pkg::*;

    nf_gpio_reg_e        reg_sel;                           // decoded offset
    logic [gpio_w-1:0]   gpi_meta;                          // first sync flop
    logic [gpio_w-1:0]   gpi_q;                             // GPI register, second flop

    assign reg_sel = nf_gpio_reg_e'(ofs);

    // input synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpi_meta <= '0;
            gpi_q    <= '0;
        end else begin
            gpi_meta <= gpi;                                // may go metastable
            gpi_q    <= gpi_meta;
        end
    end

    // output and direction registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpo <= '0;
            gpd <= '0;                                      // all pins inputs
        end else if (sel && we) begin
            case (reg_sel)
                GPIO_GPO: gpo <= wd[gpio_w-1:0];
                GPIO_GPD: gpd <= wd[gpio_w-1:0];
                default:  ;                                 // GPI is read only
            endcase
        end
    end

    // read path, zero extended
    always_ff @(posedge clk) begin
        if (sel && !we) begin
            case (reg_sel)
                GPIO_GPI: rd <= NF_DATA_W'(gpi_q);
                GPIO_GPO: rd <= NF_DATA_W'(gpo);
                GPIO_GPD: rd <= NF_DATA_W'(gpd);
                default:  rd <= '0;                         // offset 3 unused
            endcase
        end
    end

endmodule : nf_gpio

// ==== source/nf_pwm.sv ====
// ================================================
// PWM slave
// ================================================

`timescale 1ns/1ps

module nf_pwm #(
    parameter int pwm_width = 8                             // period and duty width
) (
    input  logic                             clk,           // clock
    input  logic                             rst_n,         // async reset, active low
    input  logic                             sel,           // acceptance strobe
    input  logic                             we,            // write enable
    input  logic [1:0]                       ofs,           // register offset
    input  logic [nf_pkg::NF_DATA_W-1:0]     wd,            // write data
    output logic [nf_pkg::NF_DATA_W-1:0]     rd,            // read data
    output logic                             pwm            // PWM output
);

    import nf_pkg::*;

    localparam int pre_w = 16;                              // prescaler width

    nf_pwm_reg_e           reg_sel;                         // decoded offset
    logic                  en;                              // CTRL bit 0
    logic [pre_w-1:0]      prescale;                        // clocks per tick minus one
    logic [pwm_width-1:0]  period;                          // counter wraps after this
    logic [pwm_width-1:0]  duty;                            // compare value
    logic [pre_w-1:0]      pre_cnt;                         // prescale counter
    logic [pwm_width-1:0]  per_cnt;                         // period counter
    logic                  tick;                            // advance period counter

    assign reg_sel = nf_pwm_reg_e'(ofs);
    assign tick    = (pre_cnt >= prescale);                 // >= survives a shrinking prescale

    // configuration registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en       <= 1'b0;
            prescale <= '0;
            period   <= '0;
            duty     <= '0;
        end else if (sel && we) begin
            case (reg_sel)
                PWM_CTRL:     en       <= wd[0];
                PWM_PRESCALE: prescale <= wd[pre_w-1:0];
                PWM_PERIOD:   period   <= wd[pwm_width-1:0];
                PWM_DUTY:     duty     <= wd[pwm_width-1:0];
            endcase
        end
    end

    // prescaler, period counter and output compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            per_cnt <= '0;
            pwm     <= 1'b0;
        end else if (!en) begin
            pre_cnt <= '0;                                  // hold everything cleared
            per_cnt <= '0;
            pwm     <= 1'b0;
        end else begin
            if (tick) begin
                pre_cnt <= '0;
                per_cnt <= (per_cnt >= period) ? '0 : per_cnt + 1'b1; // wrap at period
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
            pwm <= (per_cnt < duty);                        // one clock behind counter
        end
    end

    // read path, zero extended
    always_ff @(posedge clk) begin
        if (sel && !we) begin
            case (reg_sel)
                PWM_CTRL:     rd <= NF_DATA_W'(en);
                PWM_PRESCALE: rd <= NF_DATA_W'(prescale);
                PWM_PERIOD:   rd <= NF_DATA_W'(period);
                PWM_DUTY:     rd <= NF_DATA_W'(duty);
            endcase
        end
    end

endmodule : nf_pwm

// ==== source/nf_router.sv ====
// ================================================
// bus router and response combine
// ================================================

`timescale 1ns/1ps

module nf_router (
    input  logic                             clk,           // clock
    input  logic                             rst_n,         // async reset, active low
    // request channel
    input  logic                             req_valid,     // master has a request
    output logic                             req_ready,     // router can accept
    input  logic [nf_pkg::NF_ADDR_W-1:0]     req_addr,      // byte address
    input  logic                             req_we,        // write access
    input  logic [nf_pkg::NF_DATA_W-1:0]     req_wd,        // write data
    // response channel
    output logic                             rsp_valid,     // response pending
    input  logic                             rsp_ready,     // master takes response
    output logic [nf_pkg::NF_DATA_W-1:0]     rsp_rd,        // read data, zero on writes
    output logic                             rsp_err,       // unmapped access
    // slave side
    output logic                             ram_sel,       // RAM strobe
    output logic                             gpio_sel,      // GPIO strobe
    output logic                             pwm_sel,       // PWM strobe
    output logic                             slv_we,        // shared write enable
    output logic [nf_pkg::NF_OFS_W-1:0]      slv_ofs,       // shared word offset
    output logic [nf_pkg::NF_DATA_W-1:0]     slv_wd,        // shared write data
    input  logic [nf_pkg::NF_DATA_W-1:0]     ram_rd,        // RAM read data
    input  logic [nf_pkg::NF_DATA_W-1:0]     gpio_rd,       // GPIO read data
    input  logic [nf_pkg::NF_DATA_W-1:0]     pwm_rd         // PWM read data
);

    import nf_pkg::*;

    nf_rtr_state_e  state;                                  // current FSM state
    nf_rtr_state_e  state_nxt;                              // next FSM state
    nf_dev_e        dev;                                    // decoded target of request
    nf_dev_e        dev_q;                                  // target held for response
    logic           we_q;                                   // write flag held for response
    logic           accept;                                 // request handshake this edge

    // decode and slave fan out
    assign dev     = nf_dev_e'(req_addr[NF_DEV_LSB +: NF_DEV_W]);
    assign accept  = req_valid && req_ready;
    assign slv_ofs = req_addr[NF_OFS_LSB +: NF_OFS_W];
    assign slv_we  = req_we;
    assign slv_wd  = req_wd;

    assign ram_sel  = accept && (dev == DEV_RAM);
    assign gpio_sel = accept && (dev == DEV_GPIO);
    assign pwm_sel  = accept && (dev == DEV_PWM);          // DEV_NONE touches no slave

    // handshake FSM, one access in flight
    always_comb begin
        state_nxt = state;
        case (state)
            RTR_IDLE: if (accept)    state_nxt = RTR_RESP;
            RTR_RESP: if (rsp_ready) state_nxt = RTR_IDLE;  // stays here under back-pressure
            default:                 state_nxt = RTR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RTR_IDLE;
            dev_q <= DEV_RAM;
            we_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                dev_q <= dev;                               // steer the response mux
                we_q  <= req_we;
            end
        end
    end

    assign req_ready = (state == RTR_IDLE);
    assign rsp_valid = (state == RTR_RESP);
    assign rsp_err   = (dev_q == DEV_NONE);

    // read data combine, slaves hold rd until next select
    always_comb begin
        rsp_rd = '0;
        if (!we_q) begin
            case (dev_q)
                DEV_RAM:  rsp_rd = ram_rd;
                DEV_GPIO: rsp_rd = gpio_rd;
                DEV_PWM:  rsp_rd = pwm_rd;
                default:  rsp_rd = '0;                      // unmapped reads zero
            endcase
        end
    end

endmodule : nf_router

// ==== source/nf_top.sv ====
// ================================================
// peripheral subsystem top
// ================================================

`timescale 1ns/1ps

module nf_top #(
    parameter int ram_depth = 64,                           // RAM words
    parameter int gpio_w    = 8,                            // GPIO pins
    parameter int pwm_width = 8                             // PWM counter width
) (
    input  logic                             clk,           // clock
    input  logic                             rst_n,         // async reset, active low
    // request channel
    input  logic                             req_valid,     // request valid
    output logic                             req_ready,     // request ready
    input  logic [nf_pkg::NF_ADDR_W-1:0]     req_addr,      // byte address
    input  logic                             req_we,        // write access
    input  logic [nf_pkg::NF_DATA_W-1:0]     req_wd,        // write data
    // response channel
    output logic                             rsp_valid,     // response valid
    input  logic                             rsp_ready,     // response ready
    output logic [nf_pkg::NF_DATA_W-1:0]     rsp_rd,        // read data
    output logic                             rsp_err,       // unmapped access
    // pins
    input  logic [gpio_w-1:0]                gpi,           // GPIO input
    output logic [gpio_w-1:0]                gpo,           // GPIO output
    output logic [gpio_w-1:0]                gpd,           // GPIO direction
    output logic                             pwm            // PWM output
);

    import nf_pkg::*;

    localparam int ram_aw = $clog2(ram_depth);              // RAM word index bits

    logic                  ram_sel;                         // RAM strobe
    logic                  gpio_sel;                        // GPIO strobe
    logic                  pwm_sel;                         // PWM strobe
    logic                  slv_we;                          // shared write enable
    logic [NF_OFS_W-1:0]   slv_ofs;                         // shared word offset
    logic [NF_DATA_W-1:0]  slv_wd;                          // shared write data
    logic [NF_DATA_W-1:0]  ram_rd;                          // RAM read data
    logic [NF_DATA_W-1:0]  gpio_rd;                         // GPIO read data
    logic [NF_DATA_W-1:0]  pwm_rd;                          // PWM read data

    nf_router router0 (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .req_valid ( req_valid ),
        .req_ready ( req_ready ),
        .req_addr  ( req_addr  ),
        .req_we    ( req_we    ),
        .req_wd    ( req_wd    ),
        .rsp_valid ( rsp_valid ),
        .rsp_ready ( rsp_ready ),
        .rsp_rd    ( rsp_rd    ),
        .rsp_err   ( rsp_err   ),
        .ram_sel   ( ram_sel   ),
        .gpio_sel  ( gpio_sel  ),
        .pwm_sel   ( pwm_sel   ),
        .slv_we    ( slv_we    ),
        .slv_ofs   ( slv_ofs   ),
        .slv_wd    ( slv_wd    ),
        .ram_rd    ( ram_rd    ),
        .gpio_rd   ( gpio_rd   ),
        .pwm_rd    ( pwm_rd    )
    );

    nf_ram #(
        .ram_depth ( ram_depth )
    ) ram0 (
        .clk       ( clk                  ),
        .sel       ( ram_sel              ),
        .we        ( slv_we               ),
        .ofs       ( slv_ofs[ram_aw-1:0]  ),                // upper offset bits alias
        .wd        ( slv_wd               ),
        .rd        ( ram_rd               )
    );

    nf_gpio #(
        .gpio_w    ( gpio_w    )
    ) gpio0 (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .sel       ( gpio_sel     ),
        .we        ( slv_we       ),
        .ofs       ( slv_ofs[1:0] ),
        .wd        ( slv_wd       ),
        .rd        ( gpio_rd      ),
        .gpi       ( gpi          ),
        .gpo       ( gpo          ),
        .gpd       ( gpd          )
    );

    nf_pwm #(
        .pwm_width ( pwm_width )
    ) pwm0 (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .sel       ( pwm_sel      ),
        .we        ( slv_we       ),
        .ofs       ( slv_ofs[1:0] ),
        .wd        ( slv_wd       ),
        .rd        ( pwm_rd       ),
        .pwm       ( pwm          )
    );

endmodule : nf_top

// ==== dv/nf_tb_sva.sv ====
// ==================================================
// router handshake assertions
// ==================================================

`timescale 1ns/1ps

module nf_tb_sva (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          req_valid,
    input logic                          req_ready,
    input logic                          rsp_valid,
    input logic                          rsp_ready,
    input logic [nf_pkg::NF_DATA_W-1:0]  rsp_rd,
    input logic                          rsp_err
);

    int fail_cnt = 0;                                   // read by the testbench

    // no acceptance while a response is pending
    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> !req_ready)
        else begin
            fail_cnt++;
            $error("req_ready high with a response pending");
        end

    // held response under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rd) && $stable(rsp_err))
        else begin
            fail_cnt++;
            $error("response changed under back-pressure");
        end

    a_rsp_next: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready |=> rsp_valid)
        else begin
            fail_cnt++;
            $error("no response one cycle after acceptance");
        end

    a_rsp_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> $past(req_valid && req_ready))
        else begin
            fail_cnt++;
            $error("response raised without an acceptance");
        end

endmodule : nf_tb_sva

bind nf_top nf_tb_sva sva0 (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rd(rsp_rd), .rsp_err(rsp_err)
);

// ==== dv/nf_tb.sv ====
// ==================================================
// peripheral subsystem testbench
// ==================================================

`timescale 1ns/1ps

module nf_tb;

    import nf_pkg::*;

    localparam int ram_depth = 64;                          // DUT defaults
    localparam int gpio_w    = 8;
    localparam int pwm_width = 8;
    localparam int wait_tmo  = 40;                          // cycles per handshake wait
    localparam int pwm_tmo   = 2000;                        // cycles per pwm edge wait

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    logic [NF_ADDR_W-1:0]  req_addr;
    logic                  req_we;
    logic [NF_DATA_W-1:0]  req_wd;
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [NF_DATA_W-1:0]  rsp_rd;
    logic                  rsp_err;
    logic [gpio_w-1:0]     gpi;
    logic [gpio_w-1:0]     gpo;
    logic [gpio_w-1:0]     gpd;
    logic                  pwm;

    // reference model state
    logic [NF_DATA_W-1:0]  m_ram [ram_depth];
    logic [gpio_w-1:0]     m_gpi, m_gpo, m_gpd;
    logic                  m_en;
    logic [15:0]           m_pre;
    logic [pwm_width-1:0]  m_per, m_duty;

    logic [32:0]           exp_q [$];                       // {err, rd} per accepted access
    logic [32:0]           cur_exp;
    logic                  rsp_open = 1'b0;                 // response under compare
    int                    errors = 0;
    integer                seed = 32'h95d8;

    nf_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .req_we(req_we), .req_wd(req_wd),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rd(rsp_rd), .rsp_err(rsp_err),
        .gpi(gpi), .gpo(gpo), .gpd(gpd), .pwm(pwm)
    );

    always #4 clk = ~clk;                                   // 8 ns period

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_run();
        int total;
        total = errors + dut0.sva0.fail_cnt;
        $display("%0d check errors, %0d assertion failures", errors, dut0.sva0.fail_cnt);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        end_run();
    endtask

    function automatic logic [31:0] make_addr(input nf_dev_e dev, input int ofs);
        return (32'(dev) << NF_DEV_LSB) | (32'(ofs) << NF_OFS_LSB);
    endfunction

    // expected {err, rd}, updates the model on writes
    function automatic logic [32:0] ref_rsp(input logic [31:0] addr, input logic we,
                                            input logic [31:0] wd);
        nf_dev_e      dev;
        logic [9:0]   ofs;
        logic [31:0]  rd;
        dev = nf_dev_e'(addr[NF_DEV_LSB +: 2]);
        ofs = addr[NF_DEV_LSB-1:NF_OFS_LSB];
        rd  = '0;
        case (dev)
            DEV_RAM: begin
                if (we) m_ram[ofs % ram_depth] = wd;        // upper offset bits alias
                else rd = m_ram[ofs % ram_depth];
            end
            DEV_GPIO: begin
                if (we && ofs[1:0] == GPIO_GPO) m_gpo = wd[gpio_w-1:0];
                if (we && ofs[1:0] == GPIO_GPD) m_gpd = wd[gpio_w-1:0];
                if (ofs[1:0] == GPIO_GPI) rd = m_gpi;
                if (ofs[1:0] == GPIO_GPO) rd = m_gpo;
                if (ofs[1:0] == GPIO_GPD) rd = m_gpd;
            end
            DEV_PWM: begin
                if (we) begin
                    case (ofs[1:0])
                        PWM_CTRL:     m_en   = wd[0];
                        PWM_PRESCALE: m_pre  = wd[15:0];
                        PWM_PERIOD:   m_per  = wd[pwm_width-1:0];
                        default:      m_duty = wd[pwm_width-1:0];
                    endcase
                end
                case (ofs[1:0])
                    PWM_CTRL:     rd = m_en;
                    PWM_PRESCALE: rd = m_pre;
                    PWM_PERIOD:   rd = m_per;
                    default:      rd = m_duty;
                endcase
            end
            default: rd = '0;                               // unmapped, nothing stored
        endcase
        if (we) rd = '0;                                    // writes answer zero
        return {dev == DEV_NONE, rd};
    endfunction

    // one access, random back-pressure of 0 to 7 cycles on the response
    task automatic bus_access(input logic [31:0] addr, input logic we, input logic [31:0] wd);
        int   hold;
        int   cnt;
        logic hit;
        exp_q.push_back(ref_rsp(addr, we, wd));
        hold      = $unsigned($random(seed)) % 8;
        req_valid = 1'b1;
        req_addr  = addr;
        req_we    = we;
        req_wd    = wd;
        cnt = 0;
        hit = 1'b0;
        while (!hit) begin
            @(negedge clk);
            hit = req_ready;
            cnt++;
            if (!hit && cnt > wait_tmo) report_timeout("req_ready");
        end
        @(posedge clk);                                     // acceptance edge
        #1;
        req_valid = 1'b0;
        rsp_ready = (hold == 0);
        cnt = 0;
        hit = 1'b0;
        while (!hit) begin
            @(negedge clk);
            hit = rsp_valid && rsp_ready;
            cnt++;
            if (!hit) begin
                if (cnt > wait_tmo) report_timeout("the response handshake");
                @(posedge clk);
                #1;
                if (rsp_valid && cnt >= hold) rsp_ready = 1'b1;
            end
        end
        @(posedge clk);                                     // response taken here
        #1;
        rsp_ready = 1'b0;
    endtask

    // clocks from one rising edge of pwm to the next, and high clocks in between
    task automatic measure_pwm(output int high, output int per);
        int   cnt;
        logic prev;
        logic done;
        prev = 1'b1;
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = pwm && !prev;
            prev = pwm;
            cnt++;
            if (!done && cnt > pwm_tmo) report_timeout("a rising edge of pwm");
        end
        high = 1;
        per  = 1;
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (pwm && !prev) begin
                done = 1'b1;
            end else begin
                per++;
                if (pwm) high++;
            end
            prev = pwm;
            cnt++;
            if (!done && cnt > pwm_tmo) report_timeout("the next rising edge of pwm");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic pwm_setup(input int pre, input int per, input int duty);
        bus_access(make_addr(DEV_PWM, PWM_CTRL), 1'b1, 32'h0);
        bus_access(make_addr(DEV_PWM, PWM_PRESCALE), 1'b1, pre);
        bus_access(make_addr(DEV_PWM, PWM_PERIOD), 1'b1, per);
        bus_access(make_addr(DEV_PWM, PWM_DUTY), 1'b1, duty);
        bus_access(make_addr(DEV_PWM, PWM_PRESCALE), 1'b0, 32'h0);
        bus_access(make_addr(DEV_PWM, PWM_PERIOD), 1'b0, 32'h0);
        bus_access(make_addr(DEV_PWM, PWM_DUTY), 1'b0, 32'h0);
        bus_access(make_addr(DEV_PWM, PWM_CTRL), 1'b1, 32'h1);
        bus_access(make_addr(DEV_PWM, PWM_CTRL), 1'b0, 32'h0);
    endtask

    task automatic pwm_check();
        int high;
        int per;
        int exp_high;
        measure_pwm(high, per);
        exp_high = (m_duty < m_per + 1) ? m_duty : m_per + 1;
        compare_value("pwm period", per, (m_per + 1) * (m_pre + 1));
        compare_value("pwm high", high, exp_high * (m_pre + 1));
    endtask

    // compares every response cycle, so held responses must not change
    always @(negedge clk) begin
        if (rst_n === 1'b1 && rsp_valid) begin
            if (!rsp_open) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response seen with no access outstanding");
                end else begin
                    cur_exp = exp_q.pop_front();
                end
                rsp_open = 1'b1;
            end
            compare_value("rsp_rd", rsp_rd, cur_exp[31:0]);
            compare_value("rsp_err", rsp_err, cur_exp[32]);
            compare_value("req_ready", req_ready, 1'b0);    // nothing accepted meanwhile
            if (rsp_ready) rsp_open = 1'b0;
        end
    end

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_we = 1'b0;
        req_wd = '0;
        rsp_ready = 1'b0;
        gpi = '0;
        m_gpi = '0;
        m_gpo = '0;
        m_gpd = '0;
        m_en = 1'b0;
        m_pre = '0;
        m_per = '0;
        m_duty = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle outputs after reset
        compare_value("rsp_valid", rsp_valid, 1'b0);
        compare_value("req_ready", req_ready, 1'b1);
        compare_value("gpo", gpo, '0);
        compare_value("gpd", gpd, '0);
        compare_value("pwm", pwm, 1'b0);

        // RAM fill, then random traffic
        for (int i = 0; i < ram_depth; i++) begin
            bus_access(make_addr(DEV_RAM, i), 1'b1,
                       {~make_addr(DEV_RAM, i)} ^ (i * 32'h0101_0101));
        end
        repeat (40) begin
            int           rnd_ofs;
            logic [31:0]  rnd_wd;
            rnd_ofs = $unsigned($random(seed)) % ram_depth;
            rnd_wd  = $random(seed);
            bus_access(make_addr(DEV_RAM, rnd_ofs), 1'b1, rnd_wd);
            rnd_ofs = $unsigned($random(seed)) % ram_depth;
            bus_access(make_addr(DEV_RAM, rnd_ofs), 1'b0, 32'h0);
        end

        // GPIO pins and read back
        bus_access(make_addr(DEV_GPIO, GPIO_GPO), 1'b1, 32'ha5c3_5a3c);
        bus_access(make_addr(DEV_GPIO, GPIO_GPD), 1'b1, 32'h1234_56f0);
        compare_value("gpo", gpo, m_gpo);
        compare_value("gpd", gpd, m_gpd);
        bus_access(make_addr(DEV_GPIO, GPIO_GPO), 1'b0, 32'h0);
        bus_access(make_addr(DEV_GPIO, GPIO_GPD), 1'b0, 32'h0);
        bus_access(make_addr(DEV_GPIO, GPIO_GPI), 1'b1, 32'hffff_ffff); // read only
        gpi   = 8'h96;
        m_gpi = 8'h96;
        repeat (4) @(posedge clk);                          // through the synchronizer
        #1;
        bus_access(make_addr(DEV_GPIO, GPIO_GPI), 1'b0, 32'h0);
        bus_access(make_addr(DEV_GPIO, 3), 1'b0, 32'h0);

        // PWM waveforms
        pwm_setup(2, 4, 3);
        pwm_check();
        pwm_setup(0, 9, 1);
        pwm_check();
        pwm_setup(1, 3, 0);
        repeat (40) begin
            @(negedge clk);
            compare_value("pwm", pwm, 1'b0);                // zero duty stays low
        end
        @(posedge clk);
        #1;

        // unmapped device leaves the RAM alone
        bus_access(make_addr(DEV_NONE, 5), 1'b1, ~m_ram[5]);
        bus_access(make_addr(DEV_NONE, 5), 1'b0, 32'h0);
        bus_access(make_addr(DEV_RAM, 5), 1'b0, 32'h0);

        repeat (2) @(posedge clk);
        end_run();
    end

endmodule : nf_tb

// ==== build.f ====
source/nf_pkg.sv
source/nf_ram.sv
source/nf_gpio.sv
source/nf_pwm.sv
source/nf_router.sv
source/nf_top.sv
dv/nf_tb_sva.sv
dv/nf_tb.sv
